//--- result_pkg.sv
package result_pkg;

	// result word stream
	localparam int WORD_W     = 32;
	localparam int NUM_WORDS  = 3;  // words per run
	localparam int WORD_IDX_W = 2;

	// run timer
	localparam int CYCLE_W    = 64;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [CYCLE_W-1:0]    cycle_t;
	typedef logic [WORD_IDX_W-1:0] word_idx_t;

	// index of the final word of a run
	localparam word_idx_t LAST_IDX = word_idx_t'(NUM_WORDS - 1);

endpackage

//--- board_pkg.sv
package board_pkg;

	localparam int APB_ADDR_W = 8;
	localparam int APB_DATA_W = 32;

	typedef logic [APB_ADDR_W-1:0] apb_addr_t;
	typedef logic [APB_DATA_W-1:0] apb_data_t;

	// register map, byte offsets
	localparam apb_addr_t ADDR_RESULT0   = 8'h00;
	localparam apb_addr_t ADDR_RESULT1   = 8'h04;
	localparam apb_addr_t ADDR_RESULT2   = 8'h08;
	localparam apb_addr_t ADDR_DISP_PAGE = 8'h0C;
	localparam apb_addr_t ADDR_CYCLE_LO  = 8'h10; // read only
	localparam apb_addr_t ADDR_CYCLE_HI  = 8'h14; // read only
	localparam apb_addr_t ADDR_STATUS    = 8'h18; // read only

	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_DONE_BIT = 1;

	// what the six digits show
	typedef enum logic [1:0] {
		PAGE_RESULT  = 2'd0, // result word 0, bits 23..0
		PAGE_CYC_LO  = 2'd1, // cycle bits 23..0
		PAGE_CYC_MID = 2'd2, // cycle bits 47..24
		PAGE_CYC_HI  = 2'd3  // cycle bits 63..48, top two digits blank
	} disp_page_e;

	localparam int SEG_W      = 7;
	localparam int NUM_DIGITS = 6;
	localparam int NIBBLE_W   = 4;

	typedef logic [SEG_W-1:0] seg_t; // active low, bit 0 is segment a

	localparam seg_t SEG_HEX [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, // 0 1 2 3
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000, // 4 5 6 7
		7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011, // 8 9 A b
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110  // C d E F
	};

	localparam seg_t SEG_BLANK = 7'b1111111;

endpackage

//--- run_timer.sv
`timescale 1ns/1ps

module run_timer (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                go_key_n_i,   // GO key, low when pressed
	input  logic                busy_i,
	input  logic                word_valid_i,
	input  logic                last_i,
	output logic                go_o,
	output result_pkg::cycle_t  cycle_o,
	output logic                done_seen_o
);
	import result_pkg::*;

	logic key_meta;
	logic key_sync;
	logic key_prev;
	logic key_fall;

	// two-flop synchronizer, then a delayed copy for the edge detector
	always_ff @(posedge clk) begin
		if (rst_i) begin
			key_meta <= 1'b1; // released
			key_sync <= 1'b1;
			key_prev <= 1'b1;
		end else begin
			key_meta <= go_key_n_i;
			key_sync <= key_meta;
			key_prev <= key_sync;
		end
	end

	assign key_fall = key_prev & ~key_sync;

	// one pulse per press, dropped while a run is going
	always_ff @(posedge clk) begin
		if (rst_i)
			go_o <= 1'b0;
		else
			go_o <= key_fall & ~busy_i;
	end

	// run counter counts valid cycles, stops once the last word is out
	always_ff @(posedge clk) begin
		if (rst_i) begin
			cycle_o     <= '0;
			done_seen_o <= 1'b0;
		end else if (go_o) begin
			cycle_o     <= '0;
			done_seen_o <= 1'b0;
		end else begin
			if (word_valid_i && !done_seen_o)
				cycle_o <= cycle_o + cycle_t'(1);
			if (last_i)
				done_seen_o <= 1'b1; // freezes the count
		end
	end

endmodule

//--- result_sender.sv
`timescale 1ns/1ps

module result_sender (
	input  logic               clk,
	input  logic               rst_i,
	input  logic               go_i,
	input  result_pkg::word_t  result0_i,
	input  result_pkg::word_t  result1_i,
	input  result_pkg::word_t  result2_i,
	input  logic               word_ready_i,
	output result_pkg::word_t  word_o,
	output logic               word_valid_o,
	output logic               busy_o,
	output logic               last_o
);
	import result_pkg::*;

	typedef enum logic {
		IDLE = 1'b0,
		SEND = 1'b1
	} state_e;

	state_e    state;
	word_idx_t idx;
	word_t     words [NUM_WORDS]; // snapshot taken on go
	logic      xfer;

	assign word_valid_o = (state == SEND);
	assign busy_o       = (state == SEND);
	assign xfer         = word_valid_o & word_ready_i;
	assign last_o       = xfer & (idx == LAST_IDX);

	// held while stalled since idx only moves on a transfer
	assign word_o = words[idx];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= IDLE;
			idx   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (go_i) begin
						state <= SEND;
						idx   <= '0;
					end
				end
				SEND: begin
					if (xfer) begin
						if (idx == LAST_IDX)
							state <= IDLE; // valid and busy drop next cycle
						else
							idx <= idx + word_idx_t'(1);
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// host writes during a run leave the snapshot alone
	always_ff @(posedge clk) begin
		if (go_i && state == IDLE) begin
			words[0] <= result0_i;
			words[1] <= result1_i;
			words[2] <= result2_i;
		end
	end

endmodule

//--- apb_result_regs.sv
`timescale 1ns/1ps

module apb_result_regs (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic                   psel_i,
	input  logic                   penable_i,
	input  logic                   pwrite_i,
	input  board_pkg::apb_addr_t   paddr_i,
	input  board_pkg::apb_data_t   pwdata_i,
	output board_pkg::apb_data_t   prdata_o,
	output logic                   pready_o,
	output logic                   pslverr_o,
	input  result_pkg::cycle_t     cycle_i,
	input  logic                   busy_i,
	input  logic                   done_seen_i,
	output result_pkg::word_t      result0_o,
	output result_pkg::word_t      result1_o,
	output result_pkg::word_t      result2_o,
	output board_pkg::disp_page_e  disp_page_o
);
	import result_pkg::*;
	import board_pkg::*;

	logic access;
	logic addr_ok;  // address is in the map
	logic addr_ro;  // register cannot be written
	logic wr_en;

	assign access = psel_i & penable_i;

	// read mux and address decode
	always_comb begin
		addr_ok  = 1'b1;
		addr_ro  = 1'b0;
		prdata_o = '0;
		case (paddr_i)
			ADDR_RESULT0:   prdata_o = result0_o;
			ADDR_RESULT1:   prdata_o = result1_o;
			ADDR_RESULT2:   prdata_o = result2_o;
			ADDR_DISP_PAGE: prdata_o = apb_data_t'(disp_page_o);
			ADDR_CYCLE_LO: begin
				prdata_o = cycle_i[APB_DATA_W-1:0];
				addr_ro  = 1'b1;
			end
			ADDR_CYCLE_HI: begin
				prdata_o = cycle_i[CYCLE_W-1:APB_DATA_W];
				addr_ro  = 1'b1;
			end
			ADDR_STATUS: begin
				prdata_o[STATUS_BUSY_BIT] = busy_i;
				prdata_o[STATUS_DONE_BIT] = done_seen_i;
				addr_ro = 1'b1;
			end
			default: addr_ok = 1'b0;
		endcase
	end

	assign pready_o  = 1'b1; // no wait states
	assign pslverr_o = access & (~addr_ok | (pwrite_i & addr_ro));
	assign wr_en     = access & pwrite_i & addr_ok & ~addr_ro;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			result0_o   <= '0;
			result1_o   <= '0;
			result2_o   <= '0;
			disp_page_o <= PAGE_RESULT;
		end else if (wr_en) begin
			case (paddr_i)
				ADDR_RESULT0:   result0_o <= pwdata_i;
				ADDR_RESULT1:   result1_o <= pwdata_i;
				ADDR_RESULT2:   result2_o <= pwdata_i;
				ADDR_DISP_PAGE: disp_page_o <= disp_page_e'(pwdata_i[1:0]);
				default: ;
			endcase
		end
	end

endmodule

//--- hex_display.sv
`timescale 1ns/1ps

module hex_display (
	input  board_pkg::disp_page_e                        disp_page_i,
	input  result_pkg::word_t                            result0_i,
	input  result_pkg::cycle_t                           cycle_i,
	output board_pkg::seg_t [board_pkg::NUM_DIGITS-1:0]  hex_o  // [5] is leftmost
);
	import board_pkg::*;

	logic [NUM_DIGITS*NIBBLE_W-1:0] slice;
	logic [NUM_DIGITS-1:0]          blank;
	logic [NIBBLE_W-1:0]            nib [NUM_DIGITS];

	// pick the 24 bits on show for this page
	always_comb begin
		slice = '0;
		blank = '0;
		case (disp_page_i)
			PAGE_RESULT:  slice = result0_i[23:0];
			PAGE_CYC_LO:  slice = cycle_i[23:0];
			PAGE_CYC_MID: slice = cycle_i[47:24];
			PAGE_CYC_HI: begin
				slice       = {8'h00, cycle_i[63:48]};
				blank[5:4]  = 2'b11; // only 16 bits left
			end
			default: slice = '0;
		endcase
	end

	// split into nibbles, digit 0 takes the low one
	always_comb begin
		for (int d = 0; d < NUM_DIGITS; d++)
			nib[d] = slice[d*NIBBLE_W +: NIBBLE_W];
	end

	always_comb begin
		for (int d = 0; d < NUM_DIGITS; d++) begin
			if (blank[d])
				hex_o[d] = SEG_BLANK;
			else
				hex_o[d] = SEG_HEX[nib[d]];
		end
	end

endmodule

//--- result_monitor_top.sv
`timescale 1ns/1ps

module result_monitor_top (
	input  logic                                         clk,
	input  logic                                         rst_i,
	input  logic                                         psel_i,
	input  logic                                         penable_i,
	input  logic                                         pwrite_i,
	input  board_pkg::apb_addr_t                         paddr_i,
	input  board_pkg::apb_data_t                         pwdata_i,
	output board_pkg::apb_data_t                         prdata_o,
	output logic                                         pready_o,
	output logic                                         pslverr_o,
	input  logic                                         go_key_n_i,
	input  logic                                         word_ready_i,
	output result_pkg::word_t                            word_o,
	output logic                                         word_valid_o,
	output board_pkg::seg_t [board_pkg::NUM_DIGITS-1:0]  hex_o
);
	import result_pkg::*;
	import board_pkg::*;

	word_t      result0, result1, result2; // host copies of the datapath results
	disp_page_e disp_page;
	cycle_t     cycle;
	logic       go;
	logic       busy;
	logic       last;
	logic       done_seen;

	run_timer u_run_timer (
		.clk          (clk),
		.rst_i        (rst_i),
		.go_key_n_i   (go_key_n_i),
		.busy_i       (busy),
		.word_valid_i (word_valid_o),
		.last_i       (last),
		.go_o         (go),
		.cycle_o      (cycle),
		.done_seen_o  (done_seen)
	);

	result_sender u_result_sender (
		.clk          (clk),
		.rst_i        (rst_i),
		.go_i         (go),
		.result0_i    (result0),
		.result1_i    (result1),
		.result2_i    (result2),
		.word_ready_i (word_ready_i),
		.word_o       (word_o),
		.word_valid_o (word_valid_o),
		.busy_o       (busy),
		.last_o       (last)
	);

	apb_result_regs u_apb_result_regs (
		.clk         (clk),
		.rst_i       (rst_i),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.paddr_i     (paddr_i),
		.pwdata_i    (pwdata_i),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.pslverr_o   (pslverr_o),
		.cycle_i     (cycle),
		.busy_i      (busy),
		.done_seen_i (done_seen),
		.result0_o   (result0),
		.result1_o   (result1),
		.result2_o   (result2),
		.disp_page_o (disp_page)
	);

	hex_display u_hex_display (
		.disp_page_i (disp_page),
		.result0_i   (result0),
		.cycle_i     (cycle),
		.hex_o       (hex_o)
	);

endmodule

//--- result_checker.sv
`timescale 1ns/1ps

module result_checker (
	input  logic                                         clk,
	input  logic                                         rst_i,
	input  result_pkg::word_t                            word_i,
	input  logic                                         word_valid_i,
	input  logic                                         word_ready_i,
	input  board_pkg::seg_t [board_pkg::NUM_DIGITS-1:0]  hex_i
);
	import result_pkg::*;
	import board_pkg::*;

	int          n_pass;
	int          n_fail;
	int          stall_errs;
	longint      valid_cnt;  // cycles with valid high since the last clear
	word_t       got [$];    // words seen to transfer
	logic        prev_stall;
	word_t       prev_word;

	initial begin
		n_pass     = 0;
		n_fail     = 0;
		stall_errs = 0;
		valid_cnt  = 0;
		prev_stall = 1'b0;
		prev_word  = '0;
	end

	// stream watcher sees the values from before the edge
	always @(posedge clk) begin
		if (rst_i) begin
			prev_stall = 1'b0;
		end else begin
			if (prev_stall && word_i !== prev_word)
				stall_errs++; // word moved while stalled
			if (word_valid_i)
				valid_cnt++;
			if (word_valid_i && word_ready_i)
				got.push_back(word_i);
			prev_stall = word_valid_i & ~word_ready_i;
			prev_word  = word_i;
		end
	end

	// active-low hex patterns with bit 0 as segment a
	function automatic logic [6:0] seg_of(input logic [3:0] n);
		case (n)
			4'h0: return 7'h40;
			4'h1: return 7'h79;
			4'h2: return 7'h24;
			4'h3: return 7'h30;
			4'h4: return 7'h19;
			4'h5: return 7'h12;
			4'h6: return 7'h02;
			4'h7: return 7'h78;
			4'h8: return 7'h00;
			4'h9: return 7'h10;
			4'ha: return 7'h08;
			4'hb: return 7'h03;
			4'hc: return 7'h46;
			4'hd: return 7'h21;
			4'he: return 7'h06;
			default: return 7'h0e;
		endcase
	endfunction

	// expected six digits for a page with digit 5 in the top bits
	function automatic logic [41:0] display_ref(input int page, input word_t r0,
			input cycle_t cyc);
		logic [23:0] bits;
		logic [41:0] segs;
		bits = '0;
		case (page)
			0: bits = r0[23:0];
			1: bits = cyc[23:0];
			2: bits = cyc[47:24];
			default: bits = {8'h00, cyc[63:48]};
		endcase
		for (int d = 0; d < 6; d++)
			segs[d*7 +: 7] = seg_of(bits[d*4 +: 4]);
		if (page == 3)
			segs[41:28] = {14{1'b1}}; // two blank digits
		return segs;
	endfunction

	function automatic word_t expected_word(input int idx, input word_t r0, input word_t r1,
			input word_t r2);
		if (idx == 0)
			return r0;
		else if (idx == 1)
			return r1;
		return r2;
	endfunction

	function automatic cycle_t expected_count();
		return cycle_t'(valid_cnt);
	endfunction

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp === act) begin
			n_pass++;
			$display("test %s ok", name);
		end else begin
			n_fail++;
			$display("mismatch %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic note_fail(input string name, input string what);
		n_fail++;
		$display("test %s failed, %s", name, what);
	endtask

	task automatic clear_stream();
		got.delete();
		valid_cnt  = 0;
		stall_errs = 0;
	endtask

	task automatic check_stream(input string name, input word_t r0, input word_t r1,
			input word_t r2);
		if (got.size() != NUM_WORDS)
			note_fail(name, $sformatf("%0d words transferred instead of 3", got.size()));
		else
			for (int i = 0; i < NUM_WORDS; i++)
				check_val($sformatf("%s word %0d", name, i),
					64'(expected_word(i, r0, r1, r2)), 64'(got[i]));
		check_val({name, " hold"}, 64'(0), 64'(stall_errs));
	endtask

	task automatic check_display(input string name, input int page, input word_t r0,
			input cycle_t cyc);
		check_val(name, 64'(display_ref(page, r0, cyc)), 64'(hex_i));
	endtask

	task automatic summary();
		$display("checks passed %0d, failed %0d", n_pass, n_fail);
	endtask

endmodule

//--- tb_result_monitor.sv
`timescale 1ns/1ps

module tb_result_monitor;
	import result_pkg::*;
	import board_pkg::*;

	localparam int WAIT_MAX = 200; // cycles any single wait may take

	logic                        clk;
	logic                        rst_i;
	logic                        psel, penable, pwrite;
	apb_addr_t                   paddr;
	apb_data_t                   pwdata;
	apb_data_t                   prdata;
	logic                        pready, pslverr;
	logic                        go_key_n;
	logic                        word_ready;
	word_t                       word;
	logic                        word_valid;
	seg_t [NUM_DIGITS-1:0]       hex;

	integer    seed = 32'he55f2e17;
	integer    rnd;
	logic      hold_ready; // keeps the stream stalled while set
	apb_data_t rd;
	logic      err;
	word_t     r0, r1, r2;
	cycle_t    cyc;
	int        n;

	result_monitor_top u_result_monitor_top (
		.clk (clk), .rst_i (rst_i),
		.psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
		.paddr_i (paddr), .pwdata_i (pwdata), .prdata_o (prdata),
		.pready_o (pready), .pslverr_o (pslverr),
		.go_key_n_i (go_key_n), .word_ready_i (word_ready),
		.word_o (word), .word_valid_o (word_valid), .hex_o (hex)
	);

	result_checker u_checker (
		.clk (clk), .rst_i (rst_i), .word_i (word),
		.word_valid_i (word_valid), .word_ready_i (word_ready), .hex_i (hex)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// random back-pressure
	always @(posedge clk) begin
		rnd = $random(seed);
		word_ready <= rnd[0] & ~hold_ready;
	end

	// setup and access phases, sampled at the completing edge
	task automatic apb_xfer(input logic wr, input apb_addr_t a, input apb_data_t d,
			output apb_data_t q, output logic e);
		int k;
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= a;
		pwdata  <= d;
		@(posedge clk);
		penable <= 1'b1;
		k = 0;
		do begin
			@(posedge clk);
			k++;
		end while (!pready && k < WAIT_MAX);
		if (!pready)
			u_checker.note_fail("apb", "pready never came high");
		q = prdata;
		e = pslverr;
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t a, input apb_data_t d);
		apb_data_t q;
		logic e;
		apb_xfer(1'b1, a, d, q, e);
	endtask

	task automatic press_key();
		@(posedge clk);
		go_key_n <= 1'b0;
		repeat (4) @(posedge clk);
		go_key_n <= 1'b1;
	endtask

	initial begin
		rst_i      <= 1'b1;
		psel       <= 1'b0;
		penable    <= 1'b0;
		pwrite     <= 1'b0;
		paddr      <= '0;
		pwdata     <= '0;
		go_key_n   <= 1'b1;
		word_ready <= 1'b0;
		hold_ready <= 1'b0;
		repeat (2) @(posedge clk);
		rst_i <= 1'b0;
		@(posedge clk);

		// after reset
		for (int a = 0; a <= 8'h18; a += 4) begin
			apb_xfer(1'b0, apb_addr_t'(a), '0, rd, err);
			u_checker.check_val($sformatf("reset reg %h", a), 64'(0), 64'(rd));
			u_checker.check_val($sformatf("reset reg %h slverr", a), 64'(0), 64'(err));
		end
		u_checker.check_val("reset valid", 64'(0), 64'(word_valid));
		u_checker.check_display("reset display", 0, '0, '0);

		// register access
		r0 = 32'h00a1b2c3;
		r1 = 32'h5566_7788;
		r2 = 32'hdead_beef;
		apb_write(ADDR_RESULT0, r0);
		apb_write(ADDR_RESULT1, r1);
		apb_write(ADDR_RESULT2, r2);
		apb_write(ADDR_DISP_PAGE, 32'd2);
		apb_xfer(1'b0, ADDR_RESULT0, '0, rd, err);
		u_checker.check_val("rw result0", 64'(r0), 64'(rd));
		apb_xfer(1'b0, ADDR_RESULT1, '0, rd, err);
		u_checker.check_val("rw result1", 64'(r1), 64'(rd));
		apb_xfer(1'b0, ADDR_RESULT2, '0, rd, err);
		u_checker.check_val("rw result2", 64'(r2), 64'(rd));
		apb_xfer(1'b0, ADDR_DISP_PAGE, '0, rd, err);
		u_checker.check_val("rw page", 64'(2), 64'(rd));
		apb_xfer(1'b0, 8'h1c, '0, rd, err);
		u_checker.check_val("unmapped slverr", 64'(1), 64'(err));
		apb_xfer(1'b1, ADDR_CYCLE_LO, 32'h0000_dead, rd, err);
		u_checker.check_val("ro write slverr", 64'(1), 64'(err));
		apb_xfer(1'b0, ADDR_CYCLE_LO, '0, rd, err);
		u_checker.check_val("ro write unchanged", 64'(0), 64'(rd));

		// stream held off until a RESULT1 write lands in the middle of the run
		u_checker.clear_stream();
		hold_ready <= 1'b1;
		press_key();
		n = 0;
		while (!word_valid && n < WAIT_MAX) begin
			@(posedge clk);
			n++;
		end
		if (!word_valid)
			u_checker.note_fail("stream start", "word_valid never rose after the key press");
		apb_write(ADDR_RESULT1, 32'h1234_5678);
		hold_ready <= 1'b0;
		n = 0;
		while (word_valid && n < WAIT_MAX) begin
			@(posedge clk);
			n++;
		end
		if (word_valid)
			u_checker.note_fail("stream end", "word_valid never fell");
		@(posedge clk);
		u_checker.check_stream("stream", r0, r1, r2);

		// run cycle count and status
		apb_xfer(1'b0, ADDR_CYCLE_LO, '0, rd, err);
		cyc[31:0] = rd;
		apb_xfer(1'b0, ADDR_CYCLE_HI, '0, rd, err);
		cyc[63:32] = rd;
		u_checker.check_val("cycle count", 64'(u_checker.expected_count()), 64'(cyc));
		apb_xfer(1'b0, ADDR_STATUS, '0, rd, err);
		u_checker.check_val("status", 64'(2), 64'(rd));

		// all four display pages
		for (int p = 0; p < 4; p++) begin
			apb_write(ADDR_DISP_PAGE, apb_data_t'(p));
			@(posedge clk);
			u_checker.check_display($sformatf("display page %0d", p), p, r0,
				u_checker.expected_count());
		end

		u_checker.summary();
		if (u_checker.n_fail == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// last resort if the sequence itself stops moving
	initial begin
		#5ms;
		$display("simulation did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

endmodule

//--- tb.f
result_pkg.sv
board_pkg.sv
run_timer.sv
result_sender.sv
apb_result_regs.sv
hex_display.sv
result_monitor_top.sv
result_checker.sv
tb_result_monitor.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_result_monitor -o sim_result_monitor
./obj_dir/sim_result_monitor | tee sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
